//--- Bender.yml
package:
  name: fas

sources:
  - include_dirs:
      - hw
    files:
      - hw/fas_pkg.sv
      - hw/fir_filter.sv
      - hw/frame_collector.sv
      - hw/fas_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/fas_props.sv
      - test/fas_checker.sv
      - test/fas_tb.sv

//--- build.f
+incdir+hw
hw/fas_pkg.sv
hw/fir_filter.sv
hw/frame_collector.sv
hw/fas_top.sv
test/fas_props.sv
test/fas_checker.sv
test/fas_tb.sv

//--- hw/fas_config.svh
//////////////////////////////////////////////////
// Analyser front end constants
// Sample and coefficient widths, filter length,
// warm-up depth and frame size
//////////////////////////////////////////////////

`ifndef FAS_CONFIG_SVH
`define FAS_CONFIG_SVH

//////////////////////////////////////////////////
// Data path widths
//////////////////////////////////////////////////

`define FAS_SAMPLE_W   16  // Input and filtered samples
`define FAS_COEF_W     20  // Coefficients carry 16 fraction bits

// 36-bit products, plus 5 bits of growth for 32 terms
`define FAS_ACC_W      41

// Lowest sum bit that reaches the output sample
`define FAS_FRAC_LSB   16

//////////////////////////////////////////////////
// Filter and frame geometry
//////////////////////////////////////////////////

`define FAS_TAPS       32  // Delay line depth
`define FAS_WARMUP     34  // Consecutive strobes before output is valid

`define FAS_FRAME_LEN  16  // Samples per collected frame

`endif

//--- hw/fas_pkg.sv
//////////////////////////////////////////////////
// Shared types of the analyser front end
// and the low-pass coefficient table
//////////////////////////////////////////////////

`default_nettype none

`include "fas_config.svh"

package fas_pkg;

  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;  // Raw and filtered samples
  typedef logic signed [`FAS_COEF_W-1:0]   coef_t;
  typedef logic signed [`FAS_ACC_W-1:0]    acc_t;     // Full precision MAC sum
  typedef sample_t [`FAS_FRAME_LEN-1:0]    frame_t;   // Slot 0 in the low bits

  //////////////////////////////////////////////////
  // Low-pass coefficients, symmetric about taps 15 and 16
  //////////////////////////////////////////////////

  localparam coef_t fir_coefs [`FAS_TAPS] = '{
    20'hFFF9E,  // Small negative skirt at both ends
    20'hFFF86,
    20'hFFFA7,
    20'h0003B,
    20'h0014B,
    20'h0024A,
    20'h00222,
    20'hFFFE4,
    20'hFFBC5,
    20'hFF7CA,
    20'hFF74E,  // Deepest negative lobe, about -0.034
    20'hFFD74,
    20'h00B1A,
    20'h01DAC,
    20'h02F9E,
    20'h03AA9,  // Centre pair, about 0.229
    20'h03AA9,
    20'h02F9E,
    20'h01DAC,
    20'h00B1A,
    20'hFFD74,
    20'hFF74E,
    20'hFF7CA,
    20'hFFBC5,
    20'hFFFE4,
    20'h00222,
    20'h0024A,
    20'h0014B,
    20'h0003B,
    20'hFFFA7,
    20'hFFF86,
    20'hFFF9E
  };

endpackage

`default_nettype wire

//--- hw/fas_top.sv
//////////////////////////////////////////////////
// Analyser front end top level
// FIR filter feeding the frame collector
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fas_config.svh"

module fas_top
  import fas_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,   // Input sample strobe
  input  sample_t data,
  output logic    fir_valid,
  output sample_t fir_d,        // Filtered stream, also fed to the collector
  output logic    frame_valid,
  output frame_t  frame         // Slot 0 is the oldest sample of the frame
);

  //////////////////////////////////////////////////
  // Low-pass filter
  //////////////////////////////////////////////////

  fir_filter fir_filter_inst (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  //////////////////////////////////////////////////
  // Frame collector
  //////////////////////////////////////////////////

  frame_collector frame_collector_inst (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

endmodule

`default_nettype wire

//--- hw/fir_filter.sv
//////////////////////////////////////////////////
// Symmetric 32-tap low-pass FIR filter
// Sample delay line, warm-up counter, registered
// multiply-accumulate and 16-bit output rounding
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fas_config.svh"

module fir_filter
  import fas_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,  // One new sample per strobe
  input  sample_t data,
  output logic    fir_valid,   // Delay line filled by consecutive samples
  output sample_t fir_d
);

  localparam int CNT_W = $clog2(`FAS_WARMUP + 1);

  // Top magnitude bit that survives the rounding
  localparam int KEEP_MSB = `FAS_FRAC_LSB + `FAS_SAMPLE_W - 2;

  localparam logic [CNT_W-1:0] WARM_DONE = CNT_W'(`FAS_WARMUP);

  sample_t          taps [`FAS_TAPS];  // Index 0 holds the newest sample
  acc_t             prod [`FAS_TAPS];
  acc_t             dot;               // Dot product of the current taps
  acc_t             sum;
  logic [CNT_W-1:0] warm_cnt;
  logic             sum_neg;
  sample_t          trunc;

  //////////////////////////////////////////////////
  // Delay line
  //////////////////////////////////////////////////

  // Taps persist across gaps in the input stream
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `FAS_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (data_valid) begin
      taps[0] <= data;
      for (int i = 1; i < `FAS_TAPS; i++) begin
        taps[i] <= taps[i-1];  // Shift one place older
      end
    end
  end

  //////////////////////////////////////////////////
  // Warm-up counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      warm_cnt <= '0;
    end else if (!data_valid) begin
      warm_cnt <= '0;  // A gap restarts the warm-up
    end else if (warm_cnt != WARM_DONE) begin
      warm_cnt <= warm_cnt + 1'b1;
    end
  end

  assign fir_valid = (warm_cnt == WARM_DONE);

  //////////////////////////////////////////////////
  // Multiply-accumulate
  //////////////////////////////////////////////////

  // Operands are sign extended to the accumulator width before the multiply
  always_comb begin
    for (int i = 0; i < `FAS_TAPS; i++) begin
      prod[i] = taps[i] * fir_coefs[i];
    end
  end

  always_comb begin
    dot = '0;
    for (int i = 0; i < `FAS_TAPS; i++) begin
      dot = dot + prod[i];
    end
  end

  // The sum sees the taps from before this edge's shift, so coefficient 0
  // lines up with the sample accepted one strobe earlier
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum <= '0;
    end else if (data_valid) begin
      sum <= dot;
    end else begin
      sum <= '0;  // Output reads zero during a gap
    end
  end

  //////////////////////////////////////////////////
  // Output rounding
  //////////////////////////////////////////////////

  assign sum_neg = sum[`FAS_ACC_W-1];
  assign trunc   = {sum_neg, sum[KEEP_MSB:`FAS_FRAC_LSB]};  // Sign plus bits 30 to 16

  // Negative sums move up by one LSB, wrapping in 16 bits
  assign fir_d = sum_neg ? trunc + 1'b1 : trunc;

endmodule

`default_nettype wire

//--- hw/frame_collector.sv
//////////////////////////////////////////////////
// Serial to parallel frame collector
// 16-slot frame buffer filled under a slot counter
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fas_config.svh"

module frame_collector
  import fas_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    fir_valid,
  input  sample_t fir_d,
  output logic    frame_valid,  // One cycle per complete frame
  output frame_t  frame
);

  localparam int IDX_W  = $clog2(`FAS_FRAME_LEN);
  localparam int SLOT_W = IDX_W + 1;  // Counts 0 to FAS_FRAME_LEN

  localparam logic [SLOT_W-1:0] SLOT_FULL = SLOT_W'(`FAS_FRAME_LEN);

  logic [SLOT_W-1:0] slot_cnt;
  logic              capture;
  logic [IDX_W-1:0]  wr_slot;

  //////////////////////////////////////////////////
  // Slot control
  //////////////////////////////////////////////////

  // A started frame keeps capturing even once fir_valid drops
  assign capture     = fir_valid || (slot_cnt != '0);
  assign frame_valid = (slot_cnt == SLOT_FULL);

  // Low bits of a full count select slot 0 for back-to-back frames
  assign wr_slot = slot_cnt[IDX_W-1:0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt <= '0;
    end else if (capture) begin
      if (frame_valid) begin
        slot_cnt <= SLOT_W'(1);  // Slot 0 taken on this edge
      end else begin
        slot_cnt <= slot_cnt + 1'b1;
      end
    end else begin
      slot_cnt <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Frame buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame <= '0;
    end else if (capture) begin
      frame[wr_slot] <= fir_d;
    end
  end

endmodule

`default_nettype wire

//--- test/fas_checker.sv
//////////////////////////////////////////////////
// Reference model of the filter and collector
// Output comparisons, frame cadence checks and
// error counters
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fas_config.svh"

module fas_checker
  import fas_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    data_valid,
  input sample_t data,
  input logic    fir_valid,
  input sample_t fir_d,
  input logic    frame_valid,
  input frame_t  frame
);

  int reset_errs   = 0;
  int warmup_errs  = 0;
  int filter_errs  = 0;
  int frame_errs   = 0;
  int cadence_errs = 0;
  int frame_cnt    = 0;

  sample_t hist [`FAS_TAPS];          // Newest sample first
  longint  m_sum;
  int      m_warm;
  logic    m_fir_valid;
  sample_t m_fir_d;
  int      m_slot;
  sample_t m_frame [`FAS_FRAME_LEN];

  int cyc;
  int rise_cyc;
  int last_pulse;
  bit seen_rise;
  bit seen_pulse;
  bit steady;                          // Output valid since the last pulse

  function automatic longint model_dot();
    longint acc;
    acc = 0;
    for (int i = 0; i < `FAS_TAPS; i++) begin
      acc += longint'(hist[i]) * longint'(fir_coefs[i]);
    end
    return acc;
  endfunction

  // Sign, then bits 30 to 16, one LSB up when negative
  function automatic sample_t round_sum(longint s);
    sample_t kept;
    kept = {s < 0, s[`FAS_FRAC_LSB+`FAS_SAMPLE_W-2:`FAS_FRAC_LSB]};
    if (s < 0) begin
      kept = kept + 1'b1;
    end
    return kept;
  endfunction

  task clear_model();
    for (int i = 0; i < `FAS_TAPS; i++) begin
      hist[i] = '0;
    end
    for (int i = 0; i < `FAS_FRAME_LEN; i++) begin
      m_frame[i] = '0;
    end
    m_sum       = 0;
    m_warm      = 0;
    m_fir_valid = 1'b0;
    m_fir_d     = '0;
    m_slot      = 0;
    cyc         = 0;
    seen_rise   = 1'b0;
    seen_pulse  = 1'b0;
    steady      = 1'b0;
  endtask

  task check_reset();
    if (fir_valid !== 1'b0 || frame_valid !== 1'b0 || fir_d !== '0 || frame !== '0) begin
      reset_errs++;
      $display("Fail %0t: outputs not cleared during reset", $time);
    end
  endtask

  task compare_outputs();
    if (fir_valid !== m_fir_valid) begin
      warmup_errs++;
      $display("Fail %0t: fir_valid is %b, expected %b", $time, fir_valid, m_fir_valid);
    end
    if (fir_d !== m_fir_d) begin
      filter_errs++;
      $display("Fail %0t: fir_d is %h, expected %h", $time, fir_d, m_fir_d);
    end
    if (frame_valid !== (m_slot == `FAS_FRAME_LEN)) begin
      frame_errs++;
      $display("Fail %0t: frame_valid is %b, slot count %0d", $time, frame_valid, m_slot);
    end
    if (m_slot == `FAS_FRAME_LEN) begin
      for (int i = 0; i < `FAS_FRAME_LEN; i++) begin
        if (frame[i] !== m_frame[i]) begin
          frame_errs++;
          $display("Fail %0t: frame slot %0d is %h, expected %h",
                   $time, i, frame[i], m_frame[i]);
        end
      end
    end
  endtask

  task check_cadence();
    if (m_fir_valid && !seen_rise) begin
      seen_rise = 1'b1;
      rise_cyc  = cyc;
    end
    if (frame_valid) begin
      frame_cnt++;
      if (!seen_pulse) begin
        if (!seen_rise || cyc - rise_cyc != `FAS_FRAME_LEN) begin
          cadence_errs++;
          $display("Fail %0t: first frame not 16 cycles after fir_valid rose", $time);
        end
      end else if (steady && cyc - last_pulse != `FAS_FRAME_LEN) begin
        cadence_errs++;
        $display("Fail %0t: frame pulses %0d cycles apart", $time, cyc - last_pulse);
      end
      seen_pulse = 1'b1;
      last_pulse = cyc;
      steady     = m_fir_valid;
    end else if (!m_fir_valid) begin
      steady = 1'b0;
    end
  endtask

  task step_collector();
    if (m_fir_valid || m_slot != 0) begin
      if (m_slot == `FAS_FRAME_LEN) begin
        m_frame[0] = m_fir_d;
        m_slot     = 1;
      end else begin
        m_frame[m_slot] = m_fir_d;
        m_slot++;
      end
    end else begin
      m_slot = 0;
    end
  endtask

  task step_filter();
    if (data_valid) begin
      m_sum = model_dot();                 // Taps as they were before the shift
      for (int i = `FAS_TAPS - 1; i > 0; i--) begin
        hist[i] = hist[i-1];
      end
      hist[0] = data;
      if (m_warm < `FAS_WARMUP) begin
        m_warm++;
      end
    end else begin
      m_sum  = 0;
      m_warm = 0;                          // History is kept over the gap
    end
    m_fir_d     = round_sum(m_sum);
    m_fir_valid = (m_warm == `FAS_WARMUP);
  endtask

  //////////////////////////////////////////////////
  // Compare first, then advance the model
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      check_reset();
      clear_model();
    end else begin
      compare_outputs();
      check_cadence();
      step_collector();
      step_filter();
      cyc++;
    end
  end

endmodule

`default_nettype wire

//--- test/fas_props.sv
//////////////////////////////////////////////////
// Concurrent assertions on the front end ports
// Frame pulse width, warm-up origin, gap output
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fas_props
  import fas_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    data_valid,
  input logic    fir_valid,
  input sample_t fir_d,
  input logic    frame_valid
);

  int assert_errs = 0;  // Read by the testbench report

  frame_single: assert property (@(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid)
    else begin
      assert_errs++;
      $error("frame_valid stayed high for two cycles");
    end

  valid_after_strobe: assert property (@(posedge clk) disable iff (rst)
    fir_valid |-> $past(data_valid))
    else begin
      assert_errs++;
      $error("fir_valid high without a strobe on the previous cycle");
    end

  zero_after_gap: assert property (@(posedge clk) disable iff (rst)
    !data_valid |=> (fir_d == '0))
    else begin
      assert_errs++;
      $error("fir_d not zero after a cycle without a strobe");
    end

endmodule

`default_nettype wire

//--- test/fas_tb.sv
//////////////////////////////////////////////////
// Testbench of the analyser front end
// Clock, reset, random bursts, DUT, checker,
// property binding and closing report
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fas_tb
  import fas_pkg::*;
();

  localparam int RUN_CYCLES  = 1500;
  localparam int END_TIMEOUT = 4000;  // Cycles allowed for the stimulus
  localparam int DRAIN       = 40;

  logic    clk = 1'b0;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    frame_valid;
  frame_t  frame;
  logic    stim_done = 1'b0;
  integer  seed;

  always #20 clk = ~clk;

  fas_top fas_top_inst (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  fas_checker checker_inst (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  bind fas_top fas_props fas_props_inst (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid)
  );

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    int n;
    int burst_len;
    int gap_len;
    seed       = 58;
    rst        = 1'b0;
    data_valid = 1'b0;
    data       = '0;
    #5 rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    n         = 0;
    burst_len = 100;                     // Long enough for warm-up and frames
    while (n < RUN_CYCLES) begin
      for (int i = 0; i < burst_len; i++) begin
        @(posedge clk);
        data_valid <= 1'b1;
        data       <= sample_t'($random(seed));
      end
      gap_len = $unsigned($random(seed)) % 6;
      for (int i = 0; i < gap_len; i++) begin
        @(posedge clk);
        data_valid <= 1'b0;
        data       <= sample_t'($random(seed));  // Ignored while idle
      end
      n         = n + burst_len + gap_len;
      burst_len = 1 + $unsigned($random(seed)) % 120;
    end
    @(posedge clk);
    data_valid <= 1'b0;
    stim_done  <= 1'b1;
  end

  //////////////////////////////////////////////////
  // End of run
  //////////////////////////////////////////////////

  initial begin : report
    int wait_cnt;
    int total;
    wait_cnt = 0;
    while (stim_done !== 1'b1 && wait_cnt < END_TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (stim_done !== 1'b1) begin
      $display("Timeout: stimulus did not finish within %0d cycles", END_TIMEOUT);
      $display("Testbench failed");
    end else begin
      repeat (DRAIN) @(posedge clk);
      total = checker_inst.reset_errs + checker_inst.warmup_errs +
              checker_inst.filter_errs + checker_inst.frame_errs +
              checker_inst.cadence_errs + fas_top_inst.fas_props_inst.assert_errs;
      if (checker_inst.frame_cnt == 0) begin
        $display("No complete frame was seen during the run");
        total++;
      end
      $display("Errors: reset %0d warmup %0d filter %0d frame %0d cadence %0d assert %0d total %0d",
               checker_inst.reset_errs, checker_inst.warmup_errs,
               checker_inst.filter_errs, checker_inst.frame_errs,
               checker_inst.cadence_errs, fas_top_inst.fas_props_inst.assert_errs, total);
      if (total == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
